// File: logic/fir_defs.svh
// Size macros for the serial FIR subsystem.
// Include this file wherever a width or depth is needed; the guard makes
// repeated includes harmless.

`ifndef FIR_DEFS_SVH
`define FIR_DEFS_SVH

// Samples, coefficients and results are all signed Q1.15
`define FIR_DATA_WIDTH 16

// The tap memory and delay line depth must stay a power of two
`define FIR_MAX_TAPS 8
`define FIR_TAP_ADDR_WIDTH 3

`define FIR_DEST_WIDTH 4

// Two data widths plus headroom for summing every tap
`define FIR_ACC_WIDTH 35

`define FIR_FIFO_DEPTH 4
`define FIR_FIFO_ADDR_WIDTH 2

`endif

// File: logic/fir_pkg.sv
// Shared types for the serial FIR subsystem.
// Modules use these types by scoped name in their port lists and by a
// wildcard import inside their bodies.

`default_nettype none

`include "fir_defs.svh"

package fir_pkg;

    typedef logic signed [`FIR_DATA_WIDTH-1:0] sample_t;
    typedef logic signed [`FIR_DATA_WIDTH-1:0] coeff_t;

    // Tap index, delay line pointer and tap count all share this width
    typedef logic [`FIR_TAP_ADDR_WIDTH-1:0] tap_addr_t;

    typedef logic [`FIR_DEST_WIDTH-1:0] dest_t;
    typedef logic signed [`FIR_ACC_WIDTH-1:0] acc_t;

    typedef enum logic [2:0] {
        filter_clearing,
        filter_idle,
        filter_accumulating,
        filter_draining,
        filter_holding
    } filter_state_t;

endpackage

`default_nettype wire

// File: logic/dual_port_ram.sv
// Small simple dual-port RAM for the FIR engine.
// One write port and one read port with a registered output; a read of the
// address being written in the same cycle returns the previous word.

`default_nettype none

`include "fir_defs.svh"

module dual_port_ram (
    input  wire logic              clock,
    input  wire logic              write_enable,
    input  wire fir_pkg::tap_addr_t write_addr,
    input  wire fir_pkg::sample_t  write_data,
    input  wire fir_pkg::tap_addr_t read_addr,
    output fir_pkg::sample_t       read_data
);

    import fir_pkg::*;

    sample_t memory [`FIR_MAX_TAPS];

    always_ff @(posedge clock) begin
        if (write_enable) begin
            memory[write_addr] <= write_data;
        end
    end

    // The read is registered and returns the word one cycle after the address
    always_ff @(posedge clock) begin
        read_data <= memory[read_addr];
    end

endmodule

`default_nettype wire

// File: logic/sample_fifo.sv
// Valid/ready FIFO holding sample and tag pairs in front of the FIR engine.
// A pushed entry shows at the output on the next cycle. When full, a push is
// still taken in a cycle where the output side pops.

`default_nettype none

`include "fir_defs.svh"

module sample_fifo (
    input  wire logic             clock,
    input  wire logic             reset,
    input  wire logic             in_valid,
    output logic                  in_ready,
    input  wire fir_pkg::sample_t in_sample,
    input  wire fir_pkg::dest_t   in_dest,
    output logic                  out_valid,
    input  wire logic             out_ready,
    output fir_pkg::sample_t      out_sample,
    output fir_pkg::dest_t        out_dest
);

    import fir_pkg::*;

    sample_t sample_store [`FIR_FIFO_DEPTH];
    dest_t   dest_store [`FIR_FIFO_DEPTH];

    logic [`FIR_FIFO_ADDR_WIDTH-1:0] write_ptr;
    logic [`FIR_FIFO_ADDR_WIDTH-1:0] read_ptr;
    logic [`FIR_FIFO_ADDR_WIDTH:0]   count;

    logic full;
    logic push;
    logic pop;

    assign full = (count == (`FIR_FIFO_ADDR_WIDTH + 1)'(`FIR_FIFO_DEPTH));

    assign out_valid = (count != '0);
    // A full FIFO frees a slot in the same cycle it pops
    assign in_ready  = !full || out_ready;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    assign out_sample = sample_store[read_ptr];
    assign out_dest   = dest_store[read_ptr];

    always_ff @(posedge clock) begin
        if (push) begin
            sample_store[write_ptr] <= in_sample;
            dest_store[write_ptr]   <= in_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end else begin
            if (push) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (pop) begin
                read_ptr <= read_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/fir_filter_serial.sv
// Serial FIR engine, one multiply-accumulate per tap per cycle.
// Samples go into a circular delay line; coefficients come from a tap memory
// loaded through the write port. The result is held until the output
// handshake completes, so only one sample is processed at a time.

`default_nettype none

`include "fir_defs.svh"

module fir_filter_serial (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire fir_pkg::tap_addr_t n_taps,
    input  wire logic               tap_write,
    input  wire fir_pkg::tap_addr_t tap_addr,
    input  wire fir_pkg::coeff_t    tap_data,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire fir_pkg::sample_t   in_sample,
    input  wire fir_pkg::dest_t     in_dest,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output fir_pkg::sample_t        out_sample,
    output fir_pkg::dest_t          out_dest
);

    import fir_pkg::*;

    localparam tap_addr_t last_tap = tap_addr_t'(`FIR_MAX_TAPS - 1);

    filter_state_t state;

    // Points at the next delay line slot to fill and walks the line while clearing
    tap_addr_t write_ptr;
    // Slot of the sample being filtered
    tap_addr_t newest_ptr;
    tap_addr_t tap_index;

    logic      accept;
    logic      dl_write_enable;
    sample_t   dl_write_data;
    tap_addr_t dl_read_addr;

    coeff_t  current_tap;
    sample_t current_sample;
    acc_t    product;
    acc_t    accumulator;
    acc_t    next_accumulator;

    assign in_ready  = (state == filter_idle);
    assign out_valid = (state == filter_holding);
    assign accept    = in_valid && in_ready;

    // Zeros go in while clearing and the accepted sample otherwise
    assign dl_write_enable = (state == filter_clearing) || accept;
    assign dl_write_data   = (state == filter_clearing) ? '0 : in_sample;

    // Tap i pairs with the sample i steps older than the newest one
    assign dl_read_addr = newest_ptr - tap_index;

    dual_port_ram tap_memory (
        .clock        (clock),
        .write_enable (tap_write),
        .write_addr   (tap_addr),
        .write_data   (tap_data),
        .read_addr    (tap_index),
        .read_data    (current_tap)
    );

    dual_port_ram delay_line (
        .clock        (clock),
        .write_enable (dl_write_enable),
        .write_addr   (write_ptr),
        .write_data   (dl_write_data),
        .read_addr    (dl_read_addr),
        .read_data    (current_sample)
    );

    assign product          = current_tap * current_sample;
    assign next_accumulator = accumulator + product;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= filter_clearing;
            write_ptr <= '0;
            tap_index <= '0;
        end else begin
            case (state)
                filter_clearing: begin
                    write_ptr <= write_ptr + tap_addr_t'(1);
                    if (write_ptr == last_tap) begin
                        state <= filter_idle;
                    end
                end
                filter_idle: begin
                    if (accept) begin
                        write_ptr <= write_ptr + tap_addr_t'(1);
                        tap_index <= '0;
                        state     <= filter_accumulating;
                    end
                end
                filter_accumulating: begin
                    if (tap_index == n_taps) begin
                        state <= filter_draining;
                    end else begin
                        tap_index <= tap_index + tap_addr_t'(1);
                    end
                end
                filter_draining: begin
                    state <= filter_holding;
                end
                filter_holding: begin
                    if (out_ready) begin
                        state <= filter_idle;
                    end
                end
                default: begin
                    state <= filter_clearing;
                end
            endcase
        end
    end

    // The read ports lag the tap index by one cycle, so the first
    // accumulating cycle has no product yet and draining adds the last one
    always_ff @(posedge clock) begin
        if (accept) begin
            newest_ptr  <= write_ptr;
            out_dest    <= in_dest;
            accumulator <= '0;
        end
        if (state == filter_accumulating && tap_index != '0) begin
            accumulator <= next_accumulator;
        end
        if (state == filter_draining) begin
            // Scale back to Q1.15 and keep the low bits
            out_sample <= sample_t'(next_accumulator >>> (`FIR_DATA_WIDTH - 1));
        end
    end

endmodule

`default_nettype wire

// File: logic/fir_subsystem.sv
// Top level of the FIR subsystem.
// The input stream is buffered by a small FIFO and then filtered by the
// serial engine, which drives the output stream directly.

`default_nettype none

module fir_subsystem (
    input  wire logic               clock,
    input  wire logic               reset,
    input  wire logic               in_valid,
    output logic                    in_ready,
    input  wire fir_pkg::sample_t   in_sample,
    input  wire fir_pkg::dest_t     in_dest,
    input  wire logic               tap_write,
    input  wire fir_pkg::tap_addr_t tap_addr,
    input  wire fir_pkg::coeff_t    tap_data,
    input  wire fir_pkg::tap_addr_t n_taps,
    output logic                    out_valid,
    input  wire logic               out_ready,
    output fir_pkg::sample_t        out_sample,
    output fir_pkg::dest_t          out_dest
);

    import fir_pkg::*;

    // FIFO to engine stream
    logic    fifo_valid;
    logic    fifo_ready;
    sample_t fifo_sample;
    dest_t   fifo_dest;

    sample_fifo input_buffer (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_sample  (in_sample),
        .in_dest    (in_dest),
        .out_valid  (fifo_valid),
        .out_ready  (fifo_ready),
        .out_sample (fifo_sample),
        .out_dest   (fifo_dest)
    );

    fir_filter_serial filter_engine (
        .clock      (clock),
        .reset      (reset),
        .n_taps     (n_taps),
        .tap_write  (tap_write),
        .tap_addr   (tap_addr),
        .tap_data   (tap_data),
        .in_valid   (fifo_valid),
        .in_ready   (fifo_ready),
        .in_sample  (fifo_sample),
        .in_dest    (fifo_dest),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sample (out_sample),
        .out_dest   (out_dest)
    );

endmodule

`default_nettype wire

// File: testbench/fir_subsystem_tb.sv
// Self-checking testbench for the FIR subsystem.
// It loads coefficients, streams tagged samples through the DUT and compares
// every result with a reference model of the filter rule. Build and run it
// through the Makefile, which looks for the verdict line in the log.

`default_nettype none

`include "fir_defs.svh"

module fir_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import fir_pkg::*;

    // About 340 samples at up to 12 cycles each and four times over for stalls
    localparam int sample_budget     = 340;
    localparam int cycles_per_sample = 12;
    localparam int stall_factor      = 4;
    localparam int max_cycles = sample_budget * cycles_per_sample * stall_factor + 3680;

    // At most a full FIFO plus the engine's sample are pending at a drain
    localparam int drain_limit =
        2 * (`FIR_FIFO_DEPTH + 1) * cycles_per_sample * stall_factor;

    localparam coeff_t impulse_taps [`FIR_MAX_TAPS] = '{
        16'h4000, 16'hC000, 16'h2000, 16'h1234, 16'h8001, 16'h7FFF, 16'h0100, 16'hFFFF
    };

    logic      clock;
    logic      reset;
    logic      in_valid;
    logic      in_ready;
    sample_t   in_sample;
    dest_t     in_dest;
    logic      tap_write;
    tap_addr_t tap_addr;
    coeff_t    tap_data;
    tap_addr_t n_taps;
    logic      out_valid;
    logic      out_ready;
    sample_t   out_sample;
    dest_t     out_dest;

    // The model keeps its own coefficients and a history with the newest sample at index 0
    coeff_t  coeffs [`FIR_MAX_TAPS];
    sample_t history [`FIR_MAX_TAPS];
    sample_t expected_samples [$];
    dest_t   expected_dests [$];
    sample_t expected_sample;
    dest_t   expected_dest;

    logic    stall_outputs;
    logic    stalled;
    sample_t held_sample;
    dest_t   held_dest;
    int      error_count;
    int      result_count;
    int      cycle_count;

    fir_subsystem DUT (
        .clock      (clock),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_sample  (in_sample),
        .in_dest    (in_dest),
        .tap_write  (tap_write),
        .tap_addr   (tap_addr),
        .tap_data   (tap_data),
        .n_taps     (n_taps),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_sample (out_sample),
        .out_dest   (out_dest)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic compare_value(input string name, input logic signed [31:0] expected,
                                 input logic signed [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        error_count++;
    endtask

    // Sums h[i] * x[k-i] over the taps in use and scales back to Q1.15 with wrapping
    function automatic sample_t filter_reference(input int last_tap);
        longint sum;
        longint scaled;
        sum = 0;
        for (int i = 0; i <= last_tap; i++) begin
            sum = sum + longint'(coeffs[i]) * longint'(history[i]);
        end
        scaled = sum >>> 15;
        return sample_t'(scaled);
    endfunction

    // Inputs change a short time after the rising edge
    task automatic next_cycle();
        @(posedge clock);
        #10;
    endtask

    task automatic write_coeff(input int index, input coeff_t value);
        tap_write = 1'b1;
        tap_addr  = tap_addr_t'(index);
        tap_data  = value;
        coeffs[index] = value;
        next_cycle();
        tap_write = 1'b0;
    endtask

    // Holds the sample on the input until the DUT takes it
    task automatic send_sample(input sample_t sample, input dest_t dest);
        in_valid  = 1'b1;
        in_sample = sample;
        in_dest   = dest;
        do begin
            @(posedge clock);
        end while (!in_ready);
        #10;
        in_valid = 1'b0;
    endtask

    task automatic send_random(input int count, input logic with_gaps);
        for (int i = 0; i < count; i++) begin
            if (with_gaps && $urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) next_cycle();
            end
            send_sample(sample_t'($urandom()), dest_t'($urandom_range(0, 15)));
        end
    endtask

    // Waits for the queued results and gives up after a bounded number of cycles
    task automatic drain_outputs();
        int waited;
        waited = 0;
        while (expected_samples.size() != 0 && waited < drain_limit) begin
            @(negedge clock);
            waited++;
        end
        next_cycle();
    endtask

    // Reset lasts eight cycles and clearing then takes one cycle per delay slot
    task automatic apply_reset();
        reset     = 1'b1;
        in_valid  = 1'b0;
        tap_write = 1'b0;
        @(posedge clock);
        repeat (7) begin
            @(posedge clock);
            compare_value("out_valid during reset", 0, 32'(out_valid));
        end
        #10;
        reset = 1'b0;
        repeat (`FIR_MAX_TAPS) begin
            @(posedge clock);
            compare_value("out_valid while clearing", 0, 32'(out_valid));
        end
        #10;
    endtask

    // The input side of the model updates the history on every accepted sample
    always @(posedge clock) begin
        if (reset) begin
            foreach (history[i]) begin
                history[i] = '0;
            end
            expected_samples.delete();
            expected_dests.delete();
        end else if (in_valid && in_ready) begin
            for (int i = `FIR_MAX_TAPS - 1; i > 0; i--) begin
                history[i] = history[i - 1];
            end
            history[0] = in_sample;
            expected_samples.push_back(filter_reference(int'(n_taps)));
            expected_dests.push_back(in_dest);
        end
    end

    always @(posedge clock) begin
        if (reset) begin
            stalled = 1'b0;
        end else begin
            // A stalled result has to stay put until it is taken
            if (stalled) begin
                compare_value("out_valid under stall", 1, 32'(out_valid));
                compare_value("out_sample under stall", 32'(held_sample), 32'(out_sample));
                compare_value("out_dest under stall", 32'(held_dest), 32'(out_dest));
            end
            if (out_valid && out_ready) begin
                if (expected_samples.size() == 0) begin
                    report_error("the DUT sent a result that no accepted sample accounts for");
                end else begin
                    expected_sample = expected_samples.pop_front();
                    expected_dest   = expected_dests.pop_front();
                    compare_value("out_sample", 32'(expected_sample), 32'(out_sample));
                    compare_value("out_dest", 32'(expected_dest), 32'(out_dest));
                    result_count++;
                end
            end
            stalled     = out_valid && !out_ready;
            held_sample = out_sample;
            held_dest   = out_dest;
        end
    end

    initial begin
        forever begin
            next_cycle();
            out_ready = stall_outputs ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    end

    initial begin
        void'($urandom(32'h2519));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_sample     = '0;
        in_dest       = '0;
        tap_write     = 1'b0;
        tap_addr      = '0;
        tap_data      = '0;
        n_taps        = tap_addr_t'(`FIR_MAX_TAPS - 1);
        out_ready     = 1'b1;
        stall_outputs = 1'b0;
        stalled       = 1'b0;
        error_count   = 0;
        result_count  = 0;
        foreach (coeffs[i]) begin
            coeffs[i] = '0;
        end
        apply_reset();

        // An impulse of nearly one makes each output a coefficient in turn
        for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
            write_coeff(i, impulse_taps[i]);
        end
        send_sample(16'sh7FFF, 4'd1);
        for (int i = 1; i < 2 * `FIR_MAX_TAPS; i++) begin
            send_sample('0, dest_t'(i));
        end
        drain_outputs();

        for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
            write_coeff(i, coeff_t'($urandom()));
        end
        send_random(100, 1'b0);
        drain_outputs();

        // Fewer taps over the same history
        n_taps = tap_addr_t'(2);
        send_random(30, 1'b0);
        drain_outputs();
        n_taps = '0;
        send_random(30, 1'b0);
        drain_outputs();
        n_taps = tap_addr_t'(`FIR_MAX_TAPS - 1);

        stall_outputs = 1'b1;
        send_random(100, 1'b1);
        drain_outputs();

        // Reset with samples still in the FIFO and the engine
        send_random(20, 1'b0);
        apply_reset();
        stall_outputs = 1'b0;
        send_random(30, 1'b0);
        drain_outputs();

        if (expected_samples.size() != 0) begin
            report_error("results were still expected when the stimulus ended");
        end
        $display("Checks done: %0d results compared, %0d errors", result_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        report_error("timeout, the stimulus did not finish within the cycle limit");
        $display("Checks done: %0d results compared, %0d errors", result_count, error_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/fir_pkg.sv
logic/dual_port_ram.sv
logic/sample_fifo.sv
logic/fir_filter_serial.sv
logic/fir_subsystem.sv
testbench/fir_subsystem_tb.sv

// File: Makefile
# Verilator flow for the FIR subsystem: lint the RTL, build and run the
# testbench, and clean up. Every variable can be overridden on the command line,
# for example: make sim LOG=run1.log

VERILATOR  ?= verilator
FILELIST   ?= sources.f
RTL_TOP    ?= fir_subsystem
TB_TOP     ?= fir_subsystem_tb
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Test OK
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

# The run passes only when the log holds the pass line on a line of its own
sim: build
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }
	@echo "Simulation passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
